// File: common/credit_link_pkg.sv
package credit_link_pkg;

  ////////////////////////////////////////
  // widths and default sizes
  ////////////////////////////////////////

  // width of one data beat on the link and at the local ports
  localparam int unsigned DataWidth = 32;

  // a credit count fits in four bits, so at most 15 credits exist
  localparam int unsigned CreditWidth = 4;

  // default depth of every receive FIFO and the initial credit count
  localparam int unsigned DefNumCredits = 8;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [DataWidth-1:0] data_t;

  // used for every credit counter and for the credits field of a packet
  typedef logic [CreditWidth-1:0] credit_t;

  // source of the packet the sender puts on the link
  typedef enum logic {
    MODE_NORMAL,
    MODE_CREDIT_ONLY
  } pkt_mode_e;

  // waiting-credit count at which a credit-only packet is forced
  // small buffers would give a threshold below one, so it is clamped there
  function automatic int default_force_thresh(int num_credits);
    int thresh;
    thresh = num_credits - 4;
    if (thresh < 1) begin
      thresh = 1;
    end
    return thresh;
  endfunction

endpackage

// File: common/link_if.sv
interface link_if;
  import credit_link_pkg::*;

  // one direction of the link, a single packet beat per handshake
  // payload of the beat, forced to zero in a credit-only packet
  data_t   data;
  // credits handed back to the receiving side of this bundle
  credit_t credits;
  // high when the beat carries credits only and no payload
  logic    cred_only;
  logic    valid;
  logic    ready;

  // sending endpoint owns the packet fields
  modport tx (
    output data,
    output credits,
    output cred_only,
    output valid,
    input  ready
  );

  // receiving endpoint only answers with ready
  modport rx (
    input  data,
    input  credits,
    input  cred_only,
    input  valid,
    output ready
  );

endinterface

// File: hw/credit_sync/credit_sync.sv
module credit_sync #(
  parameter int NumCredits      = credit_link_pkg::DefNumCredits,
  parameter int ForceSendThresh = credit_link_pkg::default_force_thresh(NumCredits)
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  credit_link_pkg::data_t   in_data_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  credit_link_pkg::credit_t cred_recv_i,
  input  logic                     cred_recv_valid_i,
  input  logic                     buf_release_i,
  link_if.tx                       link
);
  import credit_link_pkg::*;

  // free entries left in the far receive FIFO
  credit_t   credits_available_q, credits_available_d;
  // entries our own FIFO has released and that still have to go back
  credit_t   credits_to_send_q, credits_to_send_d;
  // releases seen while a packet waits on the link, kept apart so the
  // credits field of that packet does not move
  credit_t   credits_hidden_q, credits_hidden_d;
  pkt_mode_e mode_q, mode_d;

  logic      cred_only;
  logic      can_send;
  logic      force_send;
  logic      link_hs;
  logic      link_stall;

  credit_t   avail_inc;
  credit_t   avail_dec;
  credit_t   send_inc;
  credit_t   send_dec;
  credit_t   send_offset;
  credit_t   hidden_inc;
  credit_t   hidden_dec;

  ////////////////////////////////////////
  // packet source and link outputs
  ////////////////////////////////////////

  assign cred_only  = (mode_q == MODE_CREDIT_ONLY);
  assign link_hs    = link.valid & link.ready;
  assign link_stall = link.valid & ~link.ready;

  // the last credit is only spent when credits travel back with it
  // otherwise both sides could end up waiting on credits in flight
  assign can_send = (credits_available_q > credit_t'(1)) ||
                    ((credits_available_q == credit_t'(1)) && (credits_to_send_q != '0));

  assign force_send = (credits_to_send_q >= credit_t'(ForceSendThresh));

  // data and valid pass straight through so a beat can leave in the cycle it arrives
  assign link.valid     = can_send & (in_valid_i | cred_only);
  assign link.data      = cred_only ? '0 : in_data_i;
  assign link.credits   = credits_to_send_q;
  assign link.cred_only = cred_only;

  // the local source is never acked for a credit-only packet
  assign in_ready_o = link.ready & link.valid & ~cred_only;

  always_comb begin
    mode_d = mode_q;
    if (~in_valid_i && force_send) begin
      // credits pile up with nothing to carry them so send them alone
      mode_d = MODE_CREDIT_ONLY;
    end else if (link_hs) begin
      mode_d = MODE_NORMAL;
    end
  end

  ////////////////////////////////////////
  // credit counters
  ////////////////////////////////////////

  always_comb begin
    // every packet costs one far entry, credit-only packets included
    avail_dec = '0;
    if (link_hs) begin
      avail_dec = credit_t'(1);
    end
    avail_inc = '0;
    if (cred_recv_valid_i) begin
      avail_inc = cred_recv_i;
    end
  end

  assign credits_available_d = credits_available_q + avail_inc - avail_dec;

  always_comb begin
    send_offset = '0;
    send_dec    = '0;
    send_inc    = '0;
    if (link_hs) begin
      // the packet took the visible count along and the hidden count
      // becomes visible for the next packet
      send_offset = credits_hidden_q;
      send_dec    = credits_to_send_q;
    end
    // a release while a packet is stalled goes to the hidden counter
    if (~link_stall) begin
      send_inc = credit_t'(buf_release_i);
    end
  end

  assign credits_to_send_d = credits_to_send_q + send_offset + send_inc - send_dec;

  always_comb begin
    hidden_inc = '0;
    hidden_dec = '0;
    if (link_stall) begin
      hidden_inc = credit_t'(buf_release_i);
    end
    if (link_hs) begin
      hidden_dec = credits_hidden_q;
    end
  end

  assign credits_hidden_d = credits_hidden_q + hidden_inc - hidden_dec;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits_available_q <= credit_t'(NumCredits);
      credits_to_send_q   <= '0;
      credits_hidden_q    <= '0;
      mode_q              <= MODE_NORMAL;
    end else begin
      credits_available_q <= credits_available_d;
      credits_to_send_q   <= credits_to_send_d;
      credits_hidden_q    <= credits_hidden_d;
      mode_q              <= mode_d;
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // the far side never returns more credits than it was given
  a_avail_max : assert property (
    @(posedge clk_i) disable iff (rst_i)
    credits_available_q <= credit_t'(NumCredits)
  );

  // our FIFO cannot release more entries than it holds
  a_return_max : assert property (
    @(posedge clk_i) disable iff (rst_i)
    ({1'b0, credits_to_send_q} + {1'b0, credits_hidden_q}) <= NumCredits
  );

endmodule

// File: hw/rx_buffer/rx_buffer.sv
module rx_buffer #(
  parameter int NumCredits = credit_link_pkg::DefNumCredits
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  link_if.rx                       link,
  output credit_link_pkg::credit_t cred_recv_o,
  output logic                     cred_recv_valid_o,
  output logic                     buf_release_o,
  output credit_link_pkg::data_t   out_data_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i
);
  import credit_link_pkg::*;

  localparam int PtrWidth = $clog2(NumCredits);
  localparam int CntWidth = $clog2(NumCredits + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  // storage for beats not yet taken by the local sink
  data_t   mem_q [NumCredits];
  ptr_t    wr_ptr_q;
  ptr_t    rd_ptr_q;
  cnt_t    fill_q;
  logic    ready_q;
  // releases owed to credit_sync that could not be pulsed yet
  credit_t rel_pend_q;

  logic    beat_acc;
  logic    push;
  logic    pop;
  logic    cred_only_acc;

  ////////////////////////////////////////
  // link side
  ////////////////////////////////////////

  // the credit scheme guarantees room so every beat is taken
  assign link.ready = ready_q;
  assign beat_acc   = link.valid & link.ready;

  assign push          = beat_acc & ~link.cred_only;
  assign cred_only_acc = beat_acc & link.cred_only;

  // credits ride back to our own sender in the same cycle, empty fields are dropped
  assign cred_recv_o       = link.credits;
  assign cred_recv_valid_o = beat_acc & (link.credits != '0);

  ////////////////////////////////////////
  // sink side and releases
  ////////////////////////////////////////

  assign out_valid_o = (fill_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign pop         = out_valid_o & out_ready_i;

  // a credit-only beat spent a credit at the far sender without taking an entry
  // so it is handed back as a release at once
  // when it meets a sink pop in the same cycle the extra release waits a cycle
  assign buf_release_o = pop | cred_only_acc | (rel_pend_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= link.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q    <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
      rel_pend_q <= '0;
    end else begin
      ready_q <= 1'b1;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(NumCredits - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(NumCredits - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      fill_q     <= fill_q + cnt_t'(push) - cnt_t'(pop);
      rel_pend_q <= rel_pend_q + credit_t'(pop) + credit_t'(cred_only_acc) -
                    credit_t'(buf_release_o);
    end
  end

  // the far sender must never have more packets in flight than we have entries
  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (rst_i)
    push |-> (fill_q != cnt_t'(NumCredits))
  );

endmodule

// File: hw/credit_link_top.sv
module credit_link_top #(
  parameter int NumCredits      = credit_link_pkg::DefNumCredits,
  parameter int ForceSendThresh = credit_link_pkg::default_force_thresh(NumCredits)
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // side a local ports
  input  credit_link_pkg::data_t a_in_data_i,
  input  logic                   a_in_valid_i,
  output logic                   a_in_ready_o,
  output credit_link_pkg::data_t a_out_data_o,
  output logic                   a_out_valid_o,
  input  logic                   a_out_ready_i,
  // side b local ports
  input  credit_link_pkg::data_t b_in_data_i,
  input  logic                   b_in_valid_i,
  output logic                   b_in_ready_o,
  output credit_link_pkg::data_t b_out_data_o,
  output logic                   b_out_valid_o,
  input  logic                   b_out_ready_i
);
  import credit_link_pkg::*;

  // credits each side receives and FIFO releases each side makes
  credit_t a_cred_recv;
  logic    a_cred_recv_valid;
  logic    a_buf_release;
  credit_t b_cred_recv;
  logic    b_cred_recv_valid;
  logic    b_buf_release;

  // one bundle per direction
  link_if link_ab ();
  link_if link_ba ();

  ////////////////////////////////////////
  // side a
  ////////////////////////////////////////

  credit_sync #(
    .NumCredits      (NumCredits),
    .ForceSendThresh (ForceSendThresh)
  ) u_sync_a (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .in_data_i         (a_in_data_i),
    .in_valid_i        (a_in_valid_i),
    .in_ready_o        (a_in_ready_o),
    .cred_recv_i       (a_cred_recv),
    .cred_recv_valid_i (a_cred_recv_valid),
    .buf_release_i     (a_buf_release),
    .link              (link_ab.tx)
  );

  // takes what b sends and hands b's returned credits to u_sync_a
  rx_buffer #(
    .NumCredits (NumCredits)
  ) u_rxbuf_a (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .link              (link_ba.rx),
    .cred_recv_o       (a_cred_recv),
    .cred_recv_valid_o (a_cred_recv_valid),
    .buf_release_o     (a_buf_release),
    .out_data_o        (a_out_data_o),
    .out_valid_o       (a_out_valid_o),
    .out_ready_i       (a_out_ready_i)
  );

  ////////////////////////////////////////
  // side b
  ////////////////////////////////////////

  credit_sync #(
    .NumCredits      (NumCredits),
    .ForceSendThresh (ForceSendThresh)
  ) u_sync_b (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .in_data_i         (b_in_data_i),
    .in_valid_i        (b_in_valid_i),
    .in_ready_o        (b_in_ready_o),
    .cred_recv_i       (b_cred_recv),
    .cred_recv_valid_i (b_cred_recv_valid),
    .buf_release_i     (b_buf_release),
    .link              (link_ba.tx)
  );

  rx_buffer #(
    .NumCredits (NumCredits)
  ) u_rxbuf_b (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .link              (link_ab.rx),
    .cred_recv_o       (b_cred_recv),
    .cred_recv_valid_o (b_cred_recv_valid),
    .buf_release_o     (b_buf_release),
    .out_data_o        (b_out_data_o),
    .out_valid_o       (b_out_valid_o),
    .out_ready_i       (b_out_ready_i)
  );

endmodule

// File: tb/link_checker.sv
module link_checker (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // side a handshakes as seen at the DUT ports
  input  credit_link_pkg::data_t a_in_data_i,
  input  logic                   a_in_valid_i,
  input  logic                   a_in_ready_i,
  input  credit_link_pkg::data_t a_out_data_i,
  input  logic                   a_out_valid_i,
  input  logic                   a_out_ready_i,
  // side b handshakes
  input  credit_link_pkg::data_t b_in_data_i,
  input  logic                   b_in_valid_i,
  input  logic                   b_in_ready_i,
  input  credit_link_pkg::data_t b_out_data_i,
  input  logic                   b_out_valid_i,
  input  logic                   b_out_ready_i,
  // pulsed by the testbench once a test has drained
  input  logic                   end_check_i,
  output int                     err_count_o,
  output int                     a_acc_count_o,
  output int                     ab_pend_o,
  output int                     ba_pend_o
);
  import credit_link_pkg::*;

  // reference model of each direction, oldest accepted beat at the front
  data_t q_ab[$];
  data_t q_ba[$];
  int    errs    = 0;
  int    a_acc   = 0;
  int    ab_pend = 0;
  int    ba_pend = 0;

  assign err_count_o   = errs;
  assign a_acc_count_o = a_acc;
  assign ab_pend_o     = ab_pend;
  assign ba_pend_o     = ba_pend;

  task automatic check_beat(input string port, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s delivered %h, expected %h", $time, port, got, exp);
      errs++;
    end
  endtask

  task automatic unexpected_beat(input string port, input data_t got);
    $display("%s delivered %h at time %0t while no beat was outstanding for it",
             port, got, $time);
    errs++;
  endtask

  task automatic report_leftover(input string dir, input int left);
    if (left != 0) begin
      $display("%0d beats sent %s were never delivered", left, dir);
      errs += left;
    end
  endtask

  ////////////////////////////////////////
  // sampling on the rising edge
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    data_t exp;
    if (!rst_i) begin
      // pushes come first, a beat never leaves in the cycle it enters
      if (a_in_valid_i && a_in_ready_i) begin
        q_ab.push_back(a_in_data_i);
        a_acc++;
      end
      if (b_in_valid_i && b_in_ready_i) begin
        q_ba.push_back(b_in_data_i);
      end
      if (b_out_valid_i && b_out_ready_i) begin
        if (q_ab.size() == 0) begin
          unexpected_beat("b_out", b_out_data_i);
        end else begin
          exp = q_ab.pop_front();
          check_beat("b_out", b_out_data_i, exp);
        end
      end
      if (a_out_valid_i && a_out_ready_i) begin
        if (q_ba.size() == 0) begin
          unexpected_beat("a_out", a_out_data_i);
        end else begin
          exp = q_ba.pop_front();
          check_beat("a_out", a_out_data_i, exp);
        end
      end
      // whatever is still queued here was lost by the link
      if (end_check_i) begin
        report_leftover("from a to b", q_ab.size());
        report_leftover("from b to a", q_ba.size());
        q_ab.delete();
        q_ba.delete();
      end
      ab_pend = q_ab.size();
      ba_pend = q_ba.size();
    end
  end

endmodule

// File: tb/tb_credit_link.sv
module tb_credit_link;
  import credit_link_pkg::*;

  localparam int NumCredits      = 8;
  localparam int ForceSendThresh = 4;
  // beats entered over all five tests, the run limit scales with them
  localparam int TotalBeats = 200 + 200 + 40 + 300 + 2 * 500;
  localparam int CycleLimit = TotalBeats * 20 + 1000;
  localparam int DrainLimit = 500;

  logic  clk_i = 1'b0;
  logic  rst_i;
  data_t a_in_data_i;
  logic  a_in_valid_i;
  logic  a_in_ready_o;
  data_t a_out_data_o;
  logic  a_out_valid_o;
  logic  a_out_ready_i;
  data_t b_in_data_i;
  logic  b_in_valid_i;
  logic  b_in_ready_o;
  data_t b_out_data_o;
  logic  b_out_valid_o;
  logic  b_out_ready_i;
  logic  end_check;
  logic  traffic_done;
  int    chk_errs, a_acc, ab_pend, ba_pend;
  int    tb_errs   = 0;
  int    errs_mark = 0;
  int    tests_ok  = 0;
  int    tests_bad = 0;
  int    cycles    = 0;
  int    base;
  int    seed      = 32'h1f0b99b9;

  always #4 clk_i = ~clk_i;

  credit_link_top #(
    .NumCredits      (NumCredits),
    .ForceSendThresh (ForceSendThresh)
  ) credit_link_top_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .a_in_data_i   (a_in_data_i),
    .a_in_valid_i  (a_in_valid_i),
    .a_in_ready_o  (a_in_ready_o),
    .a_out_data_o  (a_out_data_o),
    .a_out_valid_o (a_out_valid_o),
    .a_out_ready_i (a_out_ready_i),
    .b_in_data_i   (b_in_data_i),
    .b_in_valid_i  (b_in_valid_i),
    .b_in_ready_o  (b_in_ready_o),
    .b_out_data_o  (b_out_data_o),
    .b_out_valid_o (b_out_valid_o),
    .b_out_ready_i (b_out_ready_i)
  );

  link_checker link_checker_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .a_in_data_i   (a_in_data_i),
    .a_in_valid_i  (a_in_valid_i),
    .a_in_ready_i  (a_in_ready_o),
    .a_out_data_i  (a_out_data_o),
    .a_out_valid_i (a_out_valid_o),
    .a_out_ready_i (a_out_ready_i),
    .b_in_data_i   (b_in_data_i),
    .b_in_valid_i  (b_in_valid_i),
    .b_in_ready_i  (b_in_ready_o),
    .b_out_data_i  (b_out_data_o),
    .b_out_valid_i (b_out_valid_o),
    .b_out_ready_i (b_out_ready_i),
    .end_check_i   (end_check),
    .err_count_o   (chk_errs),
    .a_acc_count_o (a_acc),
    .ab_pend_o     (ab_pend),
    .ba_pend_o     (ba_pend)
  );

  // the run is stopped here if a test hangs on credits that never return
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("timeout: the run did not finish within %0d clock cycles", CycleLimit);
      $display("test failed");
      $finish;
    end
  end

  function automatic int rand_pct();
    return $unsigned($random(seed)) % 100;
  endfunction

  task automatic set_in(input bit side_b, input logic vld, input data_t dat);
    if (side_b) begin
      b_in_valid_i = vld;
      b_in_data_i  = dat;
    end else begin
      a_in_valid_i = vld;
      a_in_data_i  = dat;
    end
  endtask

  // offers n random beats at one side, valid in about valid_pct percent of cycles
  task automatic drive_side(input bit side_b, input int n, input int valid_pct);
    int    sent;
    logic  vld;
    logic  rdy;
    data_t dat;
    sent = 0;
    vld  = 1'b0;
    dat  = '0;
    while (sent < n) begin
      @(negedge clk_i);
      // a beat not yet taken keeps valid and data
      if (!vld) begin
        vld = (rand_pct() < valid_pct);
        dat = $random(seed);
      end
      set_in(side_b, vld, dat);
      @(posedge clk_i);
      rdy = side_b ? b_in_ready_o : a_in_ready_o;
      if (vld && rdy) begin
        sent++;
        vld = 1'b0;
      end
    end
    @(negedge clk_i);
    set_in(side_b, 1'b0, '0);
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_i = 1'b1;
    set_in(1'b0, 1'b0, '0);
    set_in(1'b1, 1'b0, '0);
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // credit stall watch
  ////////////////////////////////////////

  // with b silent side a has to stop one beat short of the far FIFO depth
  task automatic watch_credit_stall(input int acc0);
    int waited;
    waited = 0;
    // a stream at full rate spends its credits well within this bound
    while ((a_acc - acc0 < NumCredits - 1) && (waited < 4 * NumCredits)) begin
      @(negedge clk_i);
      waited++;
    end
    repeat (100) begin
      @(posedge clk_i);
      if (a_in_ready_o !== 1'b0) begin
        $display("mismatch at %0t: a_in_ready_o is %b while side a holds its last credit",
                 $time, a_in_ready_o);
        tb_errs++;
      end
    end
    @(negedge clk_i);
    if (a_acc - acc0 != NumCredits - 1) begin
      $display("mismatch at %0t: side a took %0d beats before credits returned, expected %0d",
               $time, a_acc - acc0, NumCredits - 1);
      tb_errs++;
    end
    // the far sink starts draining and credits flow back
    b_out_ready_i = 1'b1;
  endtask

  // waits for both reference queues to empty and lets the checker look for leftovers
  task automatic finish_test(input string name);
    int waited;
    int n;
    waited = 0;
    while ((ab_pend != 0 || ba_pend != 0) && waited < DrainLimit) begin
      @(negedge clk_i);
      waited++;
    end
    // a few idle cycles so a stray beat still shows up
    repeat (10) @(negedge clk_i);
    end_check = 1'b1;
    @(negedge clk_i);
    end_check = 1'b0;
    n = tb_errs + chk_errs - errs_mark;
    errs_mark = tb_errs + chk_errs;
    if (n == 0) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, n);
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    rst_i         = 1'b1;
    a_in_data_i   = '0;
    a_in_valid_i  = 1'b0;
    a_out_ready_i = 1'b0;
    b_in_data_i   = '0;
    b_in_valid_i  = 1'b0;
    b_out_ready_i = 1'b0;
    end_check     = 1'b0;
    traffic_done  = 1'b0;

    apply_reset();
    a_out_ready_i = 1'b1;
    b_out_ready_i = 1'b1;
    drive_side(1'b0, 200, 75);
    finish_test("[1] ordered delivery a to b");

    apply_reset();
    a_out_ready_i = 1'b1;
    b_out_ready_i = 1'b1;
    drive_side(1'b1, 200, 75);
    finish_test("[2] ordered delivery b to a");

    // b stays silent and its sink is stalled until the watch releases it
    apply_reset();
    a_out_ready_i = 1'b1;
    b_out_ready_i = 1'b0;
    base = a_acc;
    fork
      drive_side(1'b0, 40, 100);
      watch_credit_stall(base);
    join
    finish_test("[3] credit limit with a silent far side");

    // credits reach a only through credit-only packets from b
    apply_reset();
    a_out_ready_i = 1'b1;
    b_out_ready_i = 1'b1;
    drive_side(1'b0, 300, 100);
    finish_test("[4] credit return by credit-only packets");

    apply_reset();
    traffic_done = 1'b0;
    fork
      begin
        fork
          drive_side(1'b0, 500, 50);
          drive_side(1'b1, 500, 50);
        join
        traffic_done = 1'b1;
      end
      while (!traffic_done) begin
        @(negedge clk_i);
        a_out_ready_i = (rand_pct() < 50);
        b_out_ready_i = (rand_pct() < 50);
      end
    join
    a_out_ready_i = 1'b1;
    b_out_ready_i = 1'b1;
    finish_test("[5] bidirectional traffic with back-pressure");

    $display("%0d tests ok, %0d tests with errors, %0d errors in total",
             tests_ok, tests_bad, tb_errs + chk_errs);
    if (tests_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: src.f
common/credit_link_pkg.sv
common/link_if.sv
hw/credit_sync/credit_sync.sv
hw/rx_buffer/rx_buffer.sv
hw/credit_link_top.sv
tb/link_checker.sv
tb/tb_credit_link.sv

// File: Bender.yml
package:
  name: credit_link

dependencies: {}

sources:
  # shared package and link interface
  - common/credit_link_pkg.sv
  - common/link_if.sv
  # design
  - hw/credit_sync/credit_sync.sv
  - hw/rx_buffer/rx_buffer.sv
  - hw/credit_link_top.sv
  # testbench
  - target: test
    files:
      - tb/link_checker.sv
      - tb/tb_credit_link.sv
